//--- src/cpu_pkg.sv
package cpu_pkg;

	localparam int MEM_WORDS = 256;
	localparam int REG_COUNT = 32;

	typedef logic [31:0] word_t;
	typedef logic [$clog2(MEM_WORDS)-1:0] addr_t;
	typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

	typedef enum logic [5:0] {
		OP_ADD  = 6'd0,
		OP_SUB  = 6'd1,
		OP_AND  = 6'd2,
		OP_OR   = 6'd3,
		OP_XOR  = 6'd4,
		OP_ADDI = 6'd8,
		OP_LW   = 6'd9,
		OP_SW   = 6'd10,
		OP_BEQ  = 6'd11,
		OP_HALT = 6'd63
	} opcode_t;

	// Register form: rd = rs op rt.
	typedef struct packed {
		opcode_t    op;
		reg_idx_t   rd;
		reg_idx_t   rs;
		reg_idx_t   rt;
		logic [10:0] unused;
	} instr_r_t;

	// Immediate form, rt is the target or destination.
	typedef struct packed {
		opcode_t     op;
		reg_idx_t    rt;
		reg_idx_t    rs;
		logic [15:0] imm;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	// ADD r0, r0, r0.
	localparam word_t NOP_WORD = 32'h0000_0000;

endpackage

//--- src/mem_bus_if.sv
interface mem_bus_if import cpu_pkg::*; ();

	logic  req;
	logic  we;
	addr_t addr;
	word_t wdata;
	logic  gnt;
	word_t rdata;

	modport master (
		output req,
		output we,
		output addr,
		output wdata,
		input  gnt,
		input  rdata
	);

	modport slave (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output gnt,
		output rdata
	);

endinterface

//--- src/reg_bank.sv
module reg_bank import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t rs_idx,
	input  reg_idx_t rt_idx,
	output word_t    rs_val,
	output word_t    rt_val,
	input  logic     wb_en,
	input  reg_idx_t wb_idx,
	input  word_t    wb_val
);

	word_t regs [REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && wb_idx != '0) begin
			regs[wb_idx] <= wb_val;
		end
	end

	// r0 always reads zero.
	assign rs_val = (rs_idx == '0) ? '0 : regs[rs_idx];
	assign rt_val = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

//--- src/fetch_stage.sv
module fetch_stage import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      run,
	mem_bus_if.master bus,
	input  logic      stall,
	input  logic      redirect,
	input  addr_t     redirect_pc,
	output instr_u    instr,
	output addr_t     instr_pc,
	output logic      instr_valid
);

	addr_t pc;
	addr_t held_addr;
	addr_t data_pc;
	logic  live;
	logic  pending;
	logic  wait_data;
	logic  drop;
	logic  start;

	// New fetch only when its word is sure to find IF/ID free.
	assign start = live && run && !pending && !wait_data && !redirect
		&& (!instr_valid || !stall);

	assign bus.req   = pending || start;
	assign bus.addr  = pending ? held_addr : pc;
	assign bus.we    = 1'b0;
	assign bus.wdata = '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc          <= '0;
			live        <= 1'b0;
			pending     <= 1'b0;
			wait_data   <= 1'b0;
			drop        <= 1'b0;
			instr_valid <= 1'b0;
		end else begin
			live      <= 1'b1;
			pending   <= bus.req && !bus.gnt;
			wait_data <= bus.gnt;
			if (redirect) begin
				pc <= redirect_pc;
			end else if (start) begin
				pc <= pc + addr_t'(1);
			end
			// A fetch still waiting for its grant turns stale on a redirect.
			if (redirect && pending) begin
				drop <= 1'b1;
			end else if (wait_data) begin
				drop <= 1'b0;
			end
			if (redirect) begin
				instr_valid <= 1'b0;
			end else if (wait_data && !drop) begin
				instr_valid <= 1'b1;
			end else if (!stall) begin
				instr_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			held_addr <= pc;
		end
		if (bus.gnt) begin
			data_pc <= bus.addr;
		end
		if (redirect) begin
			instr <= NOP_WORD;
		end else if (wait_data && !drop) begin
			instr    <= bus.rdata;
			instr_pc <= data_pc;
		end
	end

endmodule

//--- src/exec_stage.sv
module exec_stage import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  instr_u    instr,
	input  addr_t     instr_pc,
	input  logic      instr_valid,
	mem_bus_if.master bus,
	output reg_idx_t  rs_idx,
	output reg_idx_t  rt_idx,
	input  word_t     rs_val,
	input  word_t     rt_val,
	output logic      wb_en,
	output reg_idx_t  wb_idx,
	output word_t     wb_val,
	output logic      stall,
	output logic      redirect,
	output addr_t     redirect_pc,
	output logic      halted
);

	opcode_t  op;
	logic     is_imm;
	logic     is_mem;
	logic     writes_reg;
	logic     mem_wait;
	logic     done;
	reg_idx_t dst_idx;
	word_t    imm_ext;
	word_t    rs_op;
	word_t    rt_op;
	word_t    alu_out;
	word_t    result;

	assign op         = instr.r.op;
	assign is_imm     = op inside {OP_ADDI, OP_LW, OP_SW, OP_BEQ};
	assign is_mem     = op inside {OP_LW, OP_SW};
	assign writes_reg = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LW};

	// Both views keep rs and the destination in the same bits.
	assign rs_idx  = instr.r.rs;
	assign rt_idx  = is_imm ? instr.i.rt : instr.r.rt;
	assign dst_idx = instr.r.rd;
	assign imm_ext = {{16{instr.i.imm[15]}}, instr.i.imm};

	// Bypass from the WB register, one cycle ahead of the register bank.
	assign rs_op = (wb_en && wb_idx == rs_idx && rs_idx != '0) ? wb_val : rs_val;
	assign rt_op = (wb_en && wb_idx == rt_idx && rt_idx != '0) ? wb_val : rt_val;

	always_comb begin
		case (op)
			OP_SUB:  alu_out = rs_op - rt_op;
			OP_AND:  alu_out = rs_op & rt_op;
			OP_OR:   alu_out = rs_op | rt_op;
			OP_XOR:  alu_out = rs_op ^ rt_op;
			OP_ADDI: alu_out = rs_op + imm_ext;
			default: alu_out = rs_op + rt_op;
		endcase
	end

	assign result = (op == OP_LW) ? bus.rdata : alu_out;

	// HALT never retires, so IF/ID stays full and fetch stops.
	assign stall = halted || (instr_valid && (op == OP_HALT || (is_mem && !mem_wait)));
	assign done  = instr_valid && !stall;

	assign redirect    = done && op == OP_BEQ && rs_op == rt_op;
	assign redirect_pc = instr_pc + addr_t'(1) + addr_t'(imm_ext);

	assign bus.req   = instr_valid && is_mem && !mem_wait && !halted;
	assign bus.we    = (op == OP_SW);
	assign bus.addr  = addr_t'(rs_op + imm_ext);
	assign bus.wdata = rt_op;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_en    <= 1'b0;
			mem_wait <= 1'b0;
			halted   <= 1'b0;
		end else begin
			wb_en    <= done && writes_reg;
			mem_wait <= bus.gnt;
			if (instr_valid && op == OP_HALT) begin
				halted <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			wb_idx <= dst_idx;
			wb_val <= result;
		end
	end

endmodule

//--- src/mem_arbiter.sv
module mem_arbiter import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	mem_bus_if.slave fetch_bus,
	mem_bus_if.slave data_bus,
	input  logic     host_req,
	input  logic     host_we,
	input  addr_t    host_addr,
	input  word_t    host_wdata,
	output logic     host_gnt,
	output word_t    host_rdata,
	output logic     mem_en,
	output logic     mem_we,
	output addr_t    mem_addr,
	output word_t    mem_wdata,
	input  word_t    mem_rdata
);

	logic host_last;
	logic data_last;
	logic fetch_last;

	// Host over data over fetch, nobody under reset.
	assign host_gnt      = host_req && !rst;
	assign data_bus.gnt  = data_bus.req && !host_req && !rst;
	assign fetch_bus.gnt = fetch_bus.req && !host_req && !data_bus.req && !rst;

	assign mem_en = !rst && (host_req || data_bus.req || fetch_bus.req);

	always_comb begin
		if (host_req) begin
			mem_we    = host_we;
			mem_addr  = host_addr;
			mem_wdata = host_wdata;
		end else if (data_bus.req) begin
			mem_we    = data_bus.we;
			mem_addr  = data_bus.addr;
			mem_wdata = data_bus.wdata;
		end else begin
			mem_we    = fetch_bus.we;
			mem_addr  = fetch_bus.addr;
			mem_wdata = fetch_bus.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			host_last  <= 1'b0;
			data_last  <= 1'b0;
			fetch_last <= 1'b0;
		end else begin
			host_last  <= host_gnt;
			data_last  <= data_bus.gnt;
			fetch_last <= fetch_bus.gnt;
		end
	end

	// Read data goes back only to last cycle's winner.
	assign host_rdata      = host_last ? mem_rdata : '0;
	assign data_bus.rdata  = data_last ? mem_rdata : '0;
	assign fetch_bus.rdata = fetch_last ? mem_rdata : '0;

endmodule

//--- src/unified_mem.sv
module unified_mem import cpu_pkg::*; (
	input  logic  clk,
	input  logic  en,
	input  logic  we,
	input  addr_t addr,
	input  word_t wdata,
	output word_t rdata
);

	word_t mem [MEM_WORDS];

	// Read-first on a write cycle.
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end
			rdata <= mem[addr];
		end
	end

endmodule

//--- src/cpu_top.sv
module cpu_top import cpu_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  run,
	input  logic  host_req,
	input  logic  host_we,
	input  addr_t host_addr,
	input  word_t host_wdata,
	output logic  host_gnt,
	output word_t host_rdata,
	output logic  halted
);

	mem_bus_if fetch_bus ();
	mem_bus_if data_bus ();

	instr_u   instr;
	addr_t    instr_pc;
	logic     instr_valid;
	logic     stall;
	logic     redirect;
	addr_t    redirect_pc;
	reg_idx_t rs_idx;
	reg_idx_t rt_idx;
	word_t    rs_val;
	word_t    rt_val;
	logic     wb_en;
	reg_idx_t wb_idx;
	word_t    wb_val;
	logic     mem_en;
	logic     mem_we;
	addr_t    mem_addr;
	word_t    mem_wdata;
	word_t    mem_rdata;

	fetch_stage i_fetch_stage (
		.clk         (clk),
		.rst         (rst),
		.run         (run),
		.bus         (fetch_bus),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.instr_valid (instr_valid)
	);

	exec_stage i_exec_stage (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.instr_valid (instr_valid),
		.bus         (data_bus),
		.rs_idx      (rs_idx),
		.rt_idx      (rt_idx),
		.rs_val      (rs_val),
		.rt_val      (rt_val),
		.wb_en       (wb_en),
		.wb_idx      (wb_idx),
		.wb_val      (wb_val),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.halted      (halted)
	);

	reg_bank i_reg_bank (
		.clk    (clk),
		.rst    (rst),
		.rs_idx (rs_idx),
		.rt_idx (rt_idx),
		.rs_val (rs_val),
		.rt_val (rt_val),
		.wb_en  (wb_en),
		.wb_idx (wb_idx),
		.wb_val (wb_val)
	);

	mem_arbiter i_mem_arbiter (
		.clk        (clk),
		.rst        (rst),
		.fetch_bus  (fetch_bus),
		.data_bus   (data_bus),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_gnt   (host_gnt),
		.host_rdata (host_rdata),
		.mem_en     (mem_en),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata)
	);

	unified_mem i_unified_mem (
		.clk   (clk),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

endmodule

//--- tests/clk_gen.sv
module clk_gen (
	output logic clk
);

	// Period of 4.
	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

endmodule

//--- tests/cpu_chk.sv
module cpu_chk (
	input logic clk,
	input logic rst,
	input logic host_req,
	input logic host_gnt,
	input logic data_req,
	input logic data_gnt,
	input logic fetch_req,
	input logic fetch_gnt
);

	logic [2:0] gnts;

	assign gnts = {host_gnt, data_gnt, fetch_gnt};

	one_winner: assert property (@(posedge clk) disable iff (rst) $onehot0(gnts))
		else $error("more than one memory grant in a cycle");

	// Each grant answers its own request.
	no_stray_gnt: assert property (@(posedge clk) disable iff (rst)
		(!host_gnt || host_req) && (!data_gnt || data_req) && (!fetch_gnt || fetch_req))
		else $error("memory grant without a request");

	quiet_in_reset: assert property (@(posedge clk) rst |-> gnts == 3'b000)
		else $error("memory grant while in reset");

endmodule

bind mem_arbiter cpu_chk i_cpu_chk (
	.clk       (clk),
	.rst       (rst),
	.host_req  (host_req),
	.host_gnt  (host_gnt),
	.data_req  (data_bus.req),
	.data_gnt  (data_bus.gnt),
	.fetch_req (fetch_bus.req),
	.fetch_gnt (fetch_bus.gnt)
);

//--- tests/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

	localparam int CASE_WORDS      = 256;
	localparam int CYCLES_PER_WORD = 40;
	localparam int RESET_CYCLES    = 5;

	// Record tags of the cases file.
	localparam word_t TAG_END_FILE = 32'h0;
	localparam word_t TAG_PROG     = 32'h1;
	localparam word_t TAG_EXPECT   = 32'h3;
	localparam word_t TAG_END_CASE = 32'h4;

	logic  clk;
	logic  rst;
	logic  run;
	logic  host_req;
	logic  host_we;
	addr_t host_addr;
	word_t host_wdata;
	logic  host_gnt;
	word_t host_rdata;
	logic  halted;

	word_t cases_mem [CASE_WORDS];
	int    value_errors;
	int    other_errors;
	int    limit_cycles;

	clk_gen i_clk_gen (
		.clk (clk)
	);

	cpu_top i_cpu_top (
		.clk        (clk),
		.rst        (rst),
		.run        (run),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_gnt   (host_gnt),
		.host_rdata (host_rdata),
		.halted     (halted)
	);

	task automatic reset_dut();
		@(negedge clk);
		rst      = 1'b1;
		run      = 1'b0;
		// A host read held through reset must never see a grant.
		host_req = 1'b1;
		host_we  = 1'b0;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			assert (!host_gnt) else begin
				other_errors++;
				$display("host request granted during reset at %0t", $time);
			end
		end
		rst      = 1'b0;
		host_req = 1'b0;
		assert (!halted) else begin
			other_errors++;
			$display("halted is still high after reset at %0t", $time);
		end
	endtask

	// Called on a falling edge, returns on a falling edge.
	task automatic host_access(input logic write, input addr_t addr, input word_t data,
			output word_t rdata);
		int waits;
		waits      = 0;
		host_req   = 1'b1;
		host_we    = write;
		host_addr  = addr;
		host_wdata = data;
		do begin
			@(posedge clk);
			waits++;
		end while (!host_gnt);
		@(negedge clk);
		host_req = 1'b0;
		host_we  = 1'b0;
		// Read data is valid in the cycle after the grant.
		rdata = host_rdata;
		assert (waits == 1) else begin
			other_errors++;
			$display("host access to %0h waited %0d cycles for its grant", addr, waits);
		end
	endtask

	task automatic check_word(input addr_t addr, input word_t expected);
		word_t got;
		host_access(1'b0, addr, '0, got);
		assert (got === expected) else begin
			value_errors++;
			$display("FAILED at %0t: address %0h read %h, expected %h",
				$time, addr, got, expected);
		end
	endtask

	initial begin
		int    idx;
		int    prog_words;
		word_t unused_rdata;
		addr_t exp_addr [$];
		word_t exp_data [$];

		rst          = 1'b1;
		run          = 1'b0;
		host_req     = 1'b0;
		host_we      = 1'b0;
		host_addr    = '0;
		host_wdata   = '0;
		value_errors = 0;
		other_errors = 0;
		for (int i = 0; i < CASE_WORDS; i++) begin
			cases_mem[i] = '0;
		end
		$readmemh("tests/cpu_cases.txt", cases_mem);

		prog_words = 0;
		for (int i = 0; i + 2 < CASE_WORDS; i += 3) begin
			if (cases_mem[i] == TAG_PROG) begin
				prog_words++;
			end
		end
		limit_cycles = prog_words * CYCLES_PER_WORD;

		idx = 0;
		while (idx + 2 < CASE_WORDS && cases_mem[idx] != TAG_END_FILE) begin
			prog_words = 0;
			exp_addr.delete();
			exp_data.delete();
			reset_dut();
			while (idx + 2 < CASE_WORDS && cases_mem[idx] != TAG_END_CASE) begin
				if (cases_mem[idx] == TAG_EXPECT) begin
					exp_addr.push_back(addr_t'(cases_mem[idx + 1]));
					exp_data.push_back(cases_mem[idx + 2]);
				end else begin
					if (cases_mem[idx] == TAG_PROG) begin
						prog_words++;
					end
					host_access(1'b1, addr_t'(cases_mem[idx + 1]), cases_mem[idx + 2],
						unused_rdata);
				end
				idx += 3;
			end
			idx += 3;
			if (prog_words > 0) begin
				run = 1'b1;
				while (!halted) begin
					@(negedge clk);
				end
				run = 1'b0;
				@(negedge clk);
			end else begin
				// Data only. Memory must keep it through a reset.
				reset_dut();
			end
			foreach (exp_addr[i]) begin
				check_word(exp_addr[i], exp_data[i]);
			end
			if (prog_words > 0) begin
				assert (halted) else begin
					other_errors++;
					$display("halted dropped before reset at %0t", $time);
				end
			end
		end

		$display("Error counts: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		other_errors++;
		$display("Watchdog expired after %0d cycles, a program never halted", limit_cycles);
		$display("Error counts: %0d value errors, %0d other errors", value_errors, other_errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- tests/cpu_cases.txt
// Columns: tag, word address, value (hex).
// Tag 1 program word, 2 data word, 3 expected word after halt, 4 end of case, 0 end of file.
// ALU ops, ADDI, forwarding and writes to r0.
1 00 20201234
1 01 2040FFFD
1 02 00611000
1 03 04811000
1 04 08A32000
1 05 0CC31000
1 06 10E12000
1 07 20010007
1 08 01000800
1 09 28600080
1 0A 28800081
1 0B 28A00082
1 0C 28C00083
1 0D 28E00084
1 0E 29000085
1 0F 28000086
1 10 FC000000
2 86 DEADBEEF
3 80 00001231
3 81 00001237
3 82 00001231
3 83 FFFFFFFD
3 84 00000003
3 85 00001234
3 86 00000000
4 00 00000000
// Loads, stores, load-use and BEQ taken and not taken.
1 00 20200090
1 01 24410000
1 02 00621000
1 03 24810001
1 04 28610002
1 05 2C830002
1 06 28410003
1 07 28410004
1 08 2C820001
1 09 28810005
1 0A 24A10002
1 0B 04C51000
1 0C 28C10006
1 0D FC000000
2 90 00000011
2 91 00000022
2 93 AAAA5555
2 94 5555AAAA
3 92 00000022
3 93 AAAA5555
3 94 5555AAAA
3 95 00000022
3 96 00000011
4 00 00000000
// Host writes with run low, read back after reset.
2 A0 01234567
2 A1 89ABCDEF
2 A2 FFFFFFFF
2 A3 00000000
3 A0 01234567
3 A1 89ABCDEF
3 A2 FFFFFFFF
3 A3 00000000
4 00 00000000
0 00 00000000

//--- flist.f
src/cpu_pkg.sv
src/mem_bus_if.sv
src/reg_bank.sv
src/fetch_stage.sv
src/exec_stage.sv
src/mem_arbiter.sv
src/unified_mem.sv
src/cpu_top.sv
tests/clk_gen.sv
tests/cpu_chk.sv
tests/cpu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = cpu_tb
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
